// File: dv/uart_stimulus.txt
# op byte, one operation per line
# T transmit, W write while busy, R receive, S receive during transmit
T 55
T a3
W 3c
R 5a
S c7
R 81
W f0
T 00
S 0f
R ff
S 96
T ff

// File: dv/uart_sva.sv
`default_nettype none

`include "uart_defs.svh"

module uart_sva (
    input wire clk,
    input wire reset,
    input wire tx_start,
    input wire tx_busy,
    input wire uart_tx,
    input wire rx_ready
);

    // length of the current busy stretch
    int unsigned busy_len;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_len <= 0;
        end else begin
            busy_len <= tx_busy ? busy_len + 1 : 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobe and frame rules
    ////////////////////////////////////////////////////////////////////////////

    start_pulse_one_cycle: assert property (@(posedge clk) disable iff (reset)
        tx_start |=> !tx_start)
        else $error("tx_start held for more than one cycle");

    // idle line between frames
    line_idle_when_free: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> uart_tx)
        else $error("serial line low while transmitter not busy");

    // start, eight data, two stop
    busy_frame_length: assert property (@(posedge clk) disable iff (reset)
        $fell(tx_busy) |-> (busy_len == 11 * `UART_CLK_DIV))
        else $error("tx_busy length differs from eleven bit periods");

    ready_clear_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !rx_ready)
        else $error("rx_ready set right after reset");

endmodule

// transmitter side, no receive flag here
bind uart_tx uart_sva tx_checks (
    .clk      (clk),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .uart_tx  (uart_tx),
    .rx_ready (1'b0)
);

// register side, serial line held at idle
bind uart_regs uart_sva regs_checks (
    .clk      (clk),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .uart_tx  (1'b1),
    .rx_ready (rx_ready)
);

`default_nettype wire

// File: dv/uart_tb.sv
`default_nettype none

`include "uart_defs.svh"

module uart_tb;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 cs;
    logic                 rs;
    logic                 we;
    uart_pkg::uart_byte_t din;
    uart_pkg::uart_byte_t dout;
    logic                 uart_rx;
    wire                  uart_tx;
    wire                  tx_busy;

    // stimulus entries
    logic [7:0]           ops[$];
    uart_pkg::uart_byte_t vals[$];

    int cycle_count = 0;
    int cycle_limit = 1000000;

    uart_top UUT (
        .clk     (clk),
        .reset   (reset),
        .cs      (cs),
        .rs      (rs),
        .we      (we),
        .din     (din),
        .dout    (dout),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .tx_busy (tx_busy)
    );

    always #10 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input uart_pkg::uart_byte_t expected,
                               input uart_pkg::uart_byte_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // one cycle access, inputs change on falling edge
    task automatic bus_write(input logic sel, input uart_pkg::uart_byte_t data);
        @(negedge clk);
        cs  = 1'b1;
        we  = 1'b1;
        rs  = sel;
        din = data;
        @(negedge clk);
        cs = 1'b0;
        we = 1'b0;
    endtask

    // dout valid one clock after the access
    task automatic bus_read(input logic sel, output uart_pkg::uart_byte_t data);
        @(negedge clk);
        cs = 1'b1;
        we = 1'b0;
        rs = sel;
        @(negedge clk);
        cs   = 1'b0;
        data = dout;
    endtask

    // sample each bit near its middle, then wait for busy to drop
    task automatic check_frame(input uart_pkg::uart_byte_t data, input string tag);
        logic [10:0] bits;
        int          i;
        bits = {2'b11, data, 1'b0};
        while (uart_tx === 1'b1) @(negedge clk);
        repeat (`UART_HALF_DIV) @(negedge clk);
        for (i = 0; i < 11; i++) begin
            check_value($sformatf("%s frame bit %0d", tag, i), {7'b0, bits[i]},
                        {7'b0, uart_tx});
            if (i < 10) repeat (`UART_CLK_DIV) @(negedge clk);
        end
        while (tx_busy) @(negedge clk);
    endtask

    // 8N1 frame on the serial input
    task automatic send_serial(input uart_pkg::uart_byte_t data);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            uart_rx = bits[i];
            repeat (`UART_CLK_DIV - 1) @(negedge clk);
        end
    endtask

    // poll ready, read data, then flag must be clear
    task automatic check_receive(input uart_pkg::uart_byte_t data, input string tag);
        uart_pkg::uart_byte_t status;
        uart_pkg::uart_byte_t got;
        status = '0;
        while (status[0] !== 1'b1) bus_read(1'b0, status);
        bus_read(1'b1, got);
        check_value({tag, " receive data"}, data, got);
        bus_read(1'b0, status);
        check_value({tag, " status after data read"}, 8'h02, status);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                   fd;
        int                   idx;
        int                   gap;
        string                line;
        string                tag;
        logic [7:0]           op;
        uart_pkg::uart_byte_t val;
        uart_pkg::uart_byte_t status;

        reset   = 1'b1;
        cs      = 1'b0;
        rs      = 1'b0;
        we      = 1'b0;
        din     = '0;
        uart_rx = 1'b1;
        void'($urandom(32'ha4817897));

        fd = $fopen("dv/uart_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file dv/uart_stimulus.txt");
            $display("TEST FAIL");
            $fatal(1, "no stimulus");
        end
        // comment lines start with #
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%c %h", op, val) == 2 && op != "#") begin
                ops.push_back(op);
                vals.push_back(val);
            end
        end
        $fclose(fd);
        cycle_limit = ops.size() * 14 * `UART_CLK_DIV + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // transmitter ready, nothing received
        bus_read(1'b0, status);
        check_value("reset status", 8'h02, status);
        check_value("reset line idle", 8'h01, {7'b0, uart_tx});

        for (idx = 0; idx < ops.size(); idx++) begin
            op  = ops[idx];
            val = vals[idx];
            tag = $sformatf("%c %02h", op, val);
            gap = int'($urandom % 32'd8) + 1;
            repeat (gap) @(negedge clk);
            case (op)
                "T": begin
                    bus_write(1'b1, val);
                    check_frame(val, tag);
                end
                "W": begin
                    bus_write(1'b1, val);
                    fork
                        check_frame(val, tag);
                        begin
                            // second write well inside the frame, dropped
                            repeat (3 * `UART_CLK_DIV) @(negedge clk);
                            bus_write(1'b1, ~val);
                            bus_read(1'b0, status);
                            check_value({tag, " busy status"}, 8'h00, status & 8'h02);
                        end
                    join
                    // no frame from the dropped byte
                    repeat (`UART_CLK_DIV) begin
                        @(negedge clk);
                        check_value({tag, " no second frame"}, 8'h01,
                                    {6'b0, tx_busy, uart_tx});
                    end
                end
                "R": begin
                    send_serial(val);
                    check_receive(val, tag);
                end
                "S": begin
                    // transmit the inverse while receiving
                    bus_write(1'b1, ~val);
                    fork
                        check_frame(~val, tag);
                        send_serial(val);
                    join
                    check_receive(val, tag);
                end
                default: begin
                    $display("unknown opcode in stimulus line %0d", idx);
                    $display("TEST FAIL");
                    $fatal(1, "bad stimulus");
                end
            endcase
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_top.sv
dv/uart_sva.sv
dv/uart_tb.sv

// File: hw/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// serial bit timing
////////////////////////////////////////////////////////////////////////////

// clocks per serial bit, small for simulation
`define UART_CLK_DIV 16

// start edge to middle of start bit
`define UART_HALF_DIV (`UART_CLK_DIV / 2)

////////////////////////////////////////////////////////////////////////////
// frame format
////////////////////////////////////////////////////////////////////////////

`define UART_DATA_BITS 8

// line level between frames, also stop bit level
`define UART_IDLE (1'b1)

`endif

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // data byte on bus and shifter paths
    typedef logic [7:0] uart_byte_t;

    // bit period counter, room for real clock to baud ratios
    typedef logic [12:0] baud_count_t;

    // data bit position within a frame
    typedef logic [2:0] bit_index_t;

    // transmit FSM, 8N2 frame
    typedef enum logic [2:0] {
        tx_idle,
        tx_start_bit,
        tx_data,
        tx_stop1,
        tx_stop2
    } tx_state_t;

    // receive FSM, 8N1 frame
    typedef enum logic [1:0] {
        rx_idle,
        rx_half,
        rx_data,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire

// File: hw/uart_regs.sv
`default_nettype none

module uart_regs (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cs,
    input  wire                  rs,
    input  wire                  we,
    input  wire uart_pkg::uart_byte_t din,
    output uart_pkg::uart_byte_t dout,
    input  wire                  tx_busy,
    output logic                 tx_start,
    output uart_pkg::uart_byte_t tx_byte,
    input  wire uart_pkg::uart_byte_t rx_byte,
    input  wire                  rx_done
);

    logic rx_ready;
    logic wr_access;
    logic rd_access;
    logic tx_accept;
    logic data_read;

    uart_pkg::uart_byte_t status;

    ////////////////////////////////////////////////////////////////////////////
    // bus decode
    ////////////////////////////////////////////////////////////////////////////

    // register 0 write is the control register, nothing in it yet
    assign wr_access = cs && we;
    assign rd_access = cs && !we;

    // drop tx data writes while a frame runs or a start is pending
    assign tx_accept = wr_access && rs && !tx_busy && !tx_start;

    // receive data read, clears the ready flag
    assign data_read = rd_access && rs;

    // bit 1 transmitter ready, bit 0 byte received
    assign status = {6'b000000, ~tx_busy, rx_ready};

    ////////////////////////////////////////////////////////////////////////////
    // control state and read data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_start <= 1'b0;
            rx_ready <= 1'b0;
            dout     <= '0;
        end else begin
            // single cycle start, follows the accepted write
            tx_start <= tx_accept;

            // new byte wins over a clear in the same cycle
            if (rx_done) begin
                rx_ready <= 1'b1;
            end else if (data_read) begin
                rx_ready <= 1'b0;
            end

            // read data one clock after the access
            if (rd_access) begin
                dout <= rs ? rx_byte : status;
            end
        end
    end

    // transmit holding byte, stable until tx_busy drops
    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_byte <= din;
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

`include "uart_defs.svh"

module uart_rx (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   uart_rx,
    output uart_pkg::uart_byte_t  rx_byte,
    output logic                  rx_done
);

    uart_pkg::rx_state_t   state;
    uart_pkg::baud_count_t baud_cnt;
    uart_pkg::bit_index_t  bit_idx;
    uart_pkg::uart_byte_t  rx_shift;

    logic rx_meta;
    logic rx_sync;
    logic rx_last;
    logic start_edge;
    logic half_end;
    logic bit_end;
    logic last_bit;
    logic sample_bit;
    logic frame_end;

    ////////////////////////////////////////////////////////////////////////////
    // input synchronizer and start edge
    ////////////////////////////////////////////////////////////////////////////

    // two flops into the clock domain, third one for edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= `UART_IDLE;
            rx_sync <= `UART_IDLE;
            rx_last <= `UART_IDLE;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    // idle to start level
    assign start_edge = (rx_last == `UART_IDLE) && (rx_sync != `UART_IDLE);

    assign half_end   = (baud_cnt == uart_pkg::baud_count_t'(`UART_HALF_DIV - 1));
    assign bit_end    = (baud_cnt == uart_pkg::baud_count_t'(`UART_CLK_DIV - 1));
    assign last_bit   = (bit_idx == uart_pkg::bit_index_t'(`UART_DATA_BITS - 1));
    assign sample_bit = (state == uart_pkg::rx_data) && bit_end;
    assign frame_end  = (state == uart_pkg::rx_stop) && bit_end;

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                uart_pkg::rx_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (start_edge) begin
                        state <= uart_pkg::rx_half;
                    end
                end
                uart_pkg::rx_half: begin
                    // middle of start bit, from here on whole bit steps
                    if (half_end) begin
                        baud_cnt <= '0;
                        state    <= uart_pkg::rx_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_data: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (last_bit) begin
                            state <= uart_pkg::rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_stop: begin
                    // stop bit level not checked
                    if (bit_end) begin
                        rx_done <= 1'b1;
                        state   <= uart_pkg::rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::rx_idle;
            endcase
        end
    end

    // data path, lsb arrives first so shift right
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        // output byte only changes at frame end
        if (frame_end) begin
            rx_byte <= rx_shift;
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`default_nettype none

module uart_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cs,
    input  wire                  rs,
    input  wire                  we,
    input  wire uart_pkg::uart_byte_t din,
    output uart_pkg::uart_byte_t dout,
    input  wire                  uart_rx,
    output wire                  uart_tx,
    output wire                  tx_busy
);

    // regs to transmitter
    wire                       tx_start;
    wire uart_pkg::uart_byte_t tx_byte;

    // receiver to regs
    wire uart_pkg::uart_byte_t rx_byte;
    wire                       rx_done;

    ////////////////////////////////////////////////////////////////////////////
    // cpu side registers
    ////////////////////////////////////////////////////////////////////////////

    uart_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .rs       (rs),
        .we       (we),
        .din      (din),
        .dout     (dout),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // transceiver halves
    ////////////////////////////////////////////////////////////////////////////

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .uart_tx  (uart_tx),
        .tx_busy  (tx_busy)
    );

    // serial input straight from the pin, synchronized inside
    uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .uart_rx  (uart_rx),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

`include "uart_defs.svh"

module uart_tx (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  tx_start,
    input  wire uart_pkg::uart_byte_t tx_byte,
    output logic                 uart_tx,
    output logic                 tx_busy
);

    uart_pkg::tx_state_t   state;
    uart_pkg::baud_count_t baud_cnt;
    uart_pkg::bit_index_t  bit_idx;
    uart_pkg::bit_index_t  next_idx;

    logic bit_end;
    logic last_bit;

    // last clock of the current bit period
    assign bit_end  = (baud_cnt == uart_pkg::baud_count_t'(`UART_CLK_DIV - 1));
    assign last_bit = (bit_idx == uart_pkg::bit_index_t'(`UART_DATA_BITS - 1));
    assign next_idx = bit_idx + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::tx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_tx  <= `UART_IDLE;
            tx_busy  <= 1'b0;
        end else begin
            // free running within a frame, wraps each bit
            if (state != uart_pkg::tx_idle) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end

            case (state)
                uart_pkg::tx_idle: begin
                    baud_cnt <= '0;
                    // start pulse only seen here, so ignored while busy
                    if (tx_start) begin
                        state   <= uart_pkg::tx_start_bit;
                        uart_tx <= ~(`UART_IDLE);
                        tx_busy <= 1'b1;
                    end
                end
                uart_pkg::tx_start_bit: begin
                    if (bit_end) begin
                        state   <= uart_pkg::tx_data;
                        bit_idx <= '0;
                        // lsb first
                        uart_tx <= tx_byte[0];
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_end) begin
                        if (last_bit) begin
                            state   <= uart_pkg::tx_stop1;
                            uart_tx <= `UART_IDLE;
                        end else begin
                            bit_idx <= next_idx;
                            uart_tx <= tx_byte[next_idx];
                        end
                    end
                end
                uart_pkg::tx_stop1: begin
                    // line already at stop level
                    if (bit_end) begin
                        state <= uart_pkg::tx_stop2;
                    end
                end
                uart_pkg::tx_stop2: begin
                    if (bit_end) begin
                        state   <= uart_pkg::tx_idle;
                        tx_busy <= 1'b0;
                    end
                end
                default: begin
                    state   <= uart_pkg::tx_idle;
                    uart_tx <= `UART_IDLE;
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uart_tb -f filelist.f

# a failing run exits nonzero, the pass line decides
out=$(./obj_dir/Vuart_tb 2>&1) || true
echo "$out"

if grep -qx "TEST PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
